// File: hdl/noc_bridge_pkg.sv
////////////////////////////////////////
// shared widths and types of the virtual-channel bridge
// import inside each module body, use scoped names in module headers
////////////////////////////////////////

`default_nettype none

package noc_bridge_pkg;

  // flit and link payload widths
  parameter int NarrowWidth = 32;
  parameter int WideWidth   = 64;

  // one credit count covers the deepest receive queue
  parameter int CreditWidth = 4;

  typedef logic [NarrowWidth-1:0] narrow_data_t;
  typedef logic [WideWidth-1:0]   wide_data_t;
  typedef logic [CreditWidth-1:0] credit_t;

  // channel tag carried in the link word headers
  typedef enum logic {
    VC_NARROW = 1'b0,
    VC_WIDE   = 1'b1
  } vc_e;

  // channel currently owning the transmit side of the link
  typedef enum logic {
    SEL_NARROW = 1'b0,
    SEL_WIDE   = 1'b1
  } sel_chan_e;

  ////////////////////////////////////////
  // link word
  ////////////////////////////////////////

  // narrow payloads sit in the low bits, upper bits zero
  typedef struct packed {
    logic       data_valid;
    vc_e        data_hdr;
    vc_e        credits_hdr;
    credit_t    credits;
    wide_data_t payload;
  } link_word_t;

  // credits handed back by the remote side, one channel per word
  typedef struct packed {
    logic    valid;
    vc_e     chan;
    credit_t credits;
  } cred_rpt_t;

endpackage

`default_nettype wire

// File: hdl/vc_credit_counter.sv
////////////////////////////////////////
// credit bookkeeping for one virtual channel
// gates flit acceptance on remote queue space and counts
// the credits owed back for local pops
////////////////////////////////////////

`default_nettype none

module vc_credit_counter #(
  parameter noc_bridge_pkg::vc_e Chan            = noc_bridge_pkg::VC_NARROW,
  parameter int                  NumCredits      = 4,
  parameter int                  ForceSendThresh = 3
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // flit input of this channel
  input  logic                       flit_valid_i,
  input  noc_bridge_pkg::wide_data_t flit_data_i,
  output logic                       flit_ready_o,
  // request towards the transmit arbiter
  output logic                       req_valid_o,
  output noc_bridge_pkg::wide_data_t req_data_o,
  input  logic                       grant_i,
  // owed credits for piggy-backing
  output noc_bridge_pkg::credit_t    owed_o,
  output logic                       force_o,
  input  logic                       cred_taken_i,
  // credits returned by the remote side
  input  noc_bridge_pkg::cred_rpt_t  cred_rpt_i,
  // local receive queue pop
  input  logic                       pop_i
);

  import noc_bridge_pkg::*;

  credit_t avail_q, avail_d;
  credit_t owed_q, owed_d;
  credit_t rpt_credits;
  logic    rpt_hit;

  // no request without a free slot on the far side
  assign req_valid_o  = flit_valid_i && (avail_q != '0);
  assign req_data_o   = flit_data_i;
  assign flit_ready_o = grant_i;

  // reports of the other channel are ignored
  assign rpt_hit     = cred_rpt_i.valid && (cred_rpt_i.chan == Chan);
  assign rpt_credits = rpt_hit ? cred_rpt_i.credits : '0;

  always_comb begin
    avail_d = avail_q + rpt_credits;
    if (grant_i) begin
      avail_d = avail_d - credit_t'(1);
    end
  end

  // a pop in the same cycle as a take must not be lost
  always_comb begin
    owed_d = cred_taken_i ? '0 : owed_q;
    if (pop_i) begin
      owed_d = owed_d + credit_t'(1);
    end
  end

  assign owed_o  = owed_q;
  assign force_o = (owed_q >= credit_t'(ForceSendThresh));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      avail_q <= credit_t'(NumCredits);
      owed_q  <= '0;
    end else begin
      avail_q <= avail_d;
      owed_q  <= owed_d;
    end
  end

endmodule

`default_nettype wire

// File: hdl/link_tx_arbiter.sv
////////////////////////////////////////
// transmit side of the link
// narrow-priority selection, credit piggy-back, credit-only
// words and a one-entry output register
////////////////////////////////////////

`default_nettype none

module link_tx_arbiter (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       narrow_valid_i,
  input  noc_bridge_pkg::wide_data_t narrow_data_i,
  output logic                       narrow_grant_o,
  input  logic                       wide_valid_i,
  input  noc_bridge_pkg::wide_data_t wide_data_i,
  output logic                       wide_grant_o,
  input  noc_bridge_pkg::credit_t    narrow_owed_i,
  input  noc_bridge_pkg::credit_t    wide_owed_i,
  input  logic                       force_i,
  output logic                       narrow_cred_taken_o,
  output logic                       wide_cred_taken_o,
  output logic                       link_valid_o,
  input  logic                       link_ready_i,
  output noc_bridge_pkg::link_word_t link_word_o
);

  import noc_bridge_pkg::*;

  sel_chan_e  sel_q, sel_d;
  link_word_t in_word;
  link_word_t word_q;
  logic       in_valid;
  logic       valid_q;
  logic       reg_ready;
  logic       narrow_cred_sel;
  logic       cred_only;

  // larger owed count rides along, narrow on a tie
  assign narrow_cred_sel = (narrow_owed_i >= wide_owed_i);
  assign cred_only       = !narrow_valid_i && !wide_valid_i && force_i;
  assign reg_ready       = !valid_q || link_ready_i;

  always_comb begin
    sel_d               = sel_q;
    narrow_grant_o      = 1'b0;
    wide_grant_o        = 1'b0;
    in_word             = '0;
    in_word.credits_hdr = narrow_cred_sel ? VC_NARROW : VC_WIDE;
    in_word.credits     = narrow_cred_sel ? narrow_owed_i : wide_owed_i;
    case (sel_q)
      SEL_NARROW: begin
        in_word.data_valid = narrow_valid_i;
        in_word.data_hdr   = VC_NARROW;
        if (narrow_valid_i) begin
          in_word.payload = narrow_data_i;
        end
        narrow_grant_o = narrow_valid_i && reg_ready;
        if (wide_valid_i && !narrow_valid_i) begin
          sel_d = SEL_WIDE;
        end
      end
      default: begin
        in_word.data_valid = wide_valid_i;
        in_word.data_hdr   = VC_WIDE;
        if (wide_valid_i) begin
          in_word.payload = wide_data_i;
        end
        wide_grant_o = wide_valid_i && reg_ready;
        // hand back once wide is dry or has just moved a word
        if ((!wide_valid_i || wide_grant_o) && narrow_valid_i) begin
          sel_d = SEL_NARROW;
        end
      end
    endcase
  end

  assign in_valid            = in_word.data_valid || cred_only;
  assign narrow_cred_taken_o = in_valid && reg_ready && (in_word.credits_hdr == VC_NARROW);
  assign wide_cred_taken_o   = in_valid && reg_ready && (in_word.credits_hdr == VC_WIDE);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sel_q   <= SEL_NARROW;
      valid_q <= 1'b0;
    end else begin
      sel_q <= sel_d;
      if (reg_ready) begin
        valid_q <= in_valid;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_ready && in_valid) begin
      word_q <= in_word;
    end
  end

  assign link_valid_o = valid_q;
  assign link_word_o  = word_q;

endmodule

`default_nettype wire

// File: hdl/link_rx_demux.sv
////////////////////////////////////////
// receive side of the link, purely combinational
// steers payloads to the channel queues and reports credits
////////////////////////////////////////

`default_nettype none

module link_rx_demux (
  input  logic                       link_valid_i,
  input  noc_bridge_pkg::link_word_t link_word_i,
  output logic                       link_ready_o,
  // queue pushes
  output logic                       narrow_push_o,
  output logic                       wide_push_o,
  output noc_bridge_pkg::wide_data_t push_data_o,
  input  logic                       narrow_space_i,
  input  logic                       wide_space_i,
  // returned credits for both counters
  output noc_bridge_pkg::cred_rpt_t  cred_rpt_o
);

  import noc_bridge_pkg::*;

  logic is_data;
  logic to_narrow;
  logic dst_space;

  assign is_data   = link_word_i.data_valid;
  assign to_narrow = (link_word_i.data_hdr == VC_NARROW);
  assign dst_space = to_narrow ? narrow_space_i : wide_space_i;

  // credit-only words never need queue space
  assign link_ready_o = !is_data || dst_space;

  assign narrow_push_o = link_valid_i && is_data && to_narrow && narrow_space_i;
  assign wide_push_o   = link_valid_i && is_data && !to_narrow && wide_space_i;
  assign push_data_o   = link_word_i.payload;

  ////////////////////////////////////////
  // credit report
  ////////////////////////////////////////

  // every accepted word carries credits, possibly zero
  always_comb begin
    cred_rpt_o.valid   = link_valid_i && link_ready_o;
    cred_rpt_o.chan    = link_word_i.credits_hdr;
    cred_rpt_o.credits = link_word_i.credits;
  end

endmodule

`default_nettype wire

// File: hdl/vc_rx_fifo.sv
////////////////////////////////////////
// receive queue of one virtual channel
// circular buffer, pushed data is visible one cycle later
////////////////////////////////////////

`default_nettype none

module vc_rx_fifo #(
  parameter int Width = 32,
  parameter int Depth = 4
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  logic [Width-1:0] push_data_i,
  output logic             space_o,
  output logic             pop_valid_o,
  input  logic             pop_ready_i,
  output logic [Width-1:0] pop_data_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem [Depth];
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic [CntW-1:0]  count_q;
  logic             push_en;
  logic             pop_en;

  assign space_o     = (count_q != CntW'(Depth));
  assign pop_valid_o = (count_q != '0);
  assign pop_data_o  = mem[rd_ptr_q];
  assign push_en     = push_i && space_o;
  assign pop_en      = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + PtrW'(1);
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + PtrW'(1);
      end
      count_q <= count_q + CntW'(push_en) - CntW'(pop_en);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/noc_bridge.sv
////////////////////////////////////////
// credit-based narrow/wide virtual-channel bridge
// two flit channels share one link word stream each way
////////////////////////////////////////

`default_nettype none

module noc_bridge #(
  parameter int NarrowDepth     = 4,
  parameter int WideDepth       = 4,
  parameter int ForceSendThresh = 3
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // flits from the NoC
  input  logic                         narrow_valid_i,
  output logic                         narrow_ready_o,
  input  noc_bridge_pkg::narrow_data_t narrow_data_i,
  input  logic                         wide_valid_i,
  output logic                         wide_ready_o,
  input  noc_bridge_pkg::wide_data_t   wide_data_i,
  // flits to the NoC
  output logic                         narrow_valid_o,
  input  logic                         narrow_ready_i,
  output noc_bridge_pkg::narrow_data_t narrow_data_o,
  output logic                         wide_valid_o,
  input  logic                         wide_ready_i,
  output noc_bridge_pkg::wide_data_t   wide_data_o,
  // link
  output logic                         link_valid_o,
  input  logic                         link_ready_i,
  output noc_bridge_pkg::link_word_t   link_word_o,
  input  logic                         link_valid_i,
  output logic                         link_ready_o,
  input  noc_bridge_pkg::link_word_t   link_word_i
);

  import noc_bridge_pkg::*;

  wide_data_t narrow_in_ext, narrow_req_data, wide_req_data, push_data;
  credit_t    narrow_owed, wide_owed;
  cred_rpt_t  cred_rpt;
  logic       narrow_req_valid, wide_req_valid, narrow_grant, wide_grant;
  logic       narrow_force, wide_force, narrow_cred_taken, wide_cred_taken;
  logic       narrow_push, wide_push, narrow_space, wide_space;

  // narrow flits travel zero-extended
  assign narrow_in_ext = {{(WideWidth - NarrowWidth){1'b0}}, narrow_data_i};

  vc_credit_counter #(
    .Chan(VC_NARROW), .NumCredits(NarrowDepth), .ForceSendThresh(ForceSendThresh)
  ) u_narrow_cnt (
    .clk_i, .rst_n_i,
    .flit_valid_i(narrow_valid_i), .flit_data_i(narrow_in_ext), .flit_ready_o(narrow_ready_o),
    .req_valid_o(narrow_req_valid), .req_data_o(narrow_req_data), .grant_i(narrow_grant),
    .owed_o(narrow_owed), .force_o(narrow_force), .cred_taken_i(narrow_cred_taken),
    .cred_rpt_i(cred_rpt), .pop_i(narrow_valid_o && narrow_ready_i)
  );

  vc_credit_counter #(
    .Chan(VC_WIDE), .NumCredits(WideDepth), .ForceSendThresh(ForceSendThresh)
  ) u_wide_cnt (
    .clk_i, .rst_n_i,
    .flit_valid_i(wide_valid_i), .flit_data_i(wide_data_i), .flit_ready_o(wide_ready_o),
    .req_valid_o(wide_req_valid), .req_data_o(wide_req_data), .grant_i(wide_grant),
    .owed_o(wide_owed), .force_o(wide_force), .cred_taken_i(wide_cred_taken),
    .cred_rpt_i(cred_rpt), .pop_i(wide_valid_o && wide_ready_i)
  );

  link_tx_arbiter u_tx_arb (
    .clk_i, .rst_n_i,
    .narrow_valid_i(narrow_req_valid), .narrow_data_i(narrow_req_data),
    .narrow_grant_o(narrow_grant),
    .wide_valid_i(wide_req_valid), .wide_data_i(wide_req_data), .wide_grant_o(wide_grant),
    .narrow_owed_i(narrow_owed), .wide_owed_i(wide_owed),
    .force_i(narrow_force || wide_force),
    .narrow_cred_taken_o(narrow_cred_taken), .wide_cred_taken_o(wide_cred_taken),
    .link_valid_o, .link_ready_i, .link_word_o
  );

  ////////////////////////////////////////
  // receive path
  ////////////////////////////////////////

  link_rx_demux u_rx_demux (
    .link_valid_i, .link_word_i, .link_ready_o,
    .narrow_push_o(narrow_push), .wide_push_o(wide_push), .push_data_o(push_data),
    .narrow_space_i(narrow_space), .wide_space_i(wide_space), .cred_rpt_o(cred_rpt)
  );

  // narrow queue only stores the low payload bits
  vc_rx_fifo #(.Width(NarrowWidth), .Depth(NarrowDepth)) u_narrow_fifo (
    .clk_i, .rst_n_i,
    .push_i(narrow_push), .push_data_i(push_data[NarrowWidth-1:0]), .space_o(narrow_space),
    .pop_valid_o(narrow_valid_o), .pop_ready_i(narrow_ready_i), .pop_data_o(narrow_data_o)
  );

  vc_rx_fifo #(.Width(WideWidth), .Depth(WideDepth)) u_wide_fifo (
    .clk_i, .rst_n_i,
    .push_i(wide_push), .push_data_i(push_data), .space_o(wide_space),
    .pop_valid_o(wide_valid_o), .pop_ready_i(wide_ready_i), .pop_data_o(wide_data_o)
  );

endmodule

`default_nettype wire

// File: dv/noc_bridge_checker.sv
////////////////////////////////////////
// link protocol checks for the bridge
// bound into noc_bridge by the testbench
////////////////////////////////////////

`default_nettype none

module noc_bridge_checker #(
  parameter int NarrowDepth = 4,
  parameter int WideDepth   = 4
) (
  input logic                               clk_i,
  input logic                               rst_n_i,
  input logic                               link_out_valid_i,
  input logic                               link_out_ready_i,
  input noc_bridge_pkg::link_word_t         link_out_word_i,
  input logic                               link_in_valid_i,
  input logic                               link_in_ready_i,
  input noc_bridge_pkg::link_word_t         link_in_word_i,
  input logic                               narrow_pop_i,
  input logic                               wide_pop_i,
  input logic [$clog2(NarrowDepth+1)-1:0]   narrow_fill_i,
  input logic [$clog2(WideDepth+1)-1:0]     wide_fill_i,
  input logic                               narrow_out_valid_i,
  input logic                               wide_out_valid_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // read by the testbench at the end of the run
  int fail_count = 0;

  // outputs come up idle out of reset
  reset_idle_a: assert property (@(posedge clk_i)
    !rst_n_i |=> !link_out_valid_i && !narrow_out_valid_i && !wide_out_valid_i)
    else begin
      $error("link or flit output valid right after reset");
      fail_count++;
    end

  // a stalled word holds until taken
  link_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_out_valid_i && !link_out_ready_i |=> link_out_valid_i && $stable(link_out_word_i))
    else begin
      $error("link word changed or dropped while stalled");
      fail_count++;
    end

  // credits guarantee queue space on the receive side
  no_refusal_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_in_valid_i |-> link_in_ready_i)
    else begin
      $error("incoming link word refused");
      fail_count++;
    end

  // credit-only words leave the queue fill levels alone
  narrow_cred_only_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_in_valid_i && !link_in_word_i.data_valid && !narrow_pop_i
    |=> $stable(narrow_fill_i))
    else begin
      $error("credit-only link word changed the narrow queue fill");
      fail_count++;
    end

  wide_cred_only_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_in_valid_i && !link_in_word_i.data_valid && !wide_pop_i
    |=> $stable(wide_fill_i))
    else begin
      $error("credit-only link word changed the wide queue fill");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: dv/noc_bridge_tb.sv
////////////////////////////////////////
// testbench of the bridge, link looped back onto itself
// random traffic, credit bound and credit-only return phases
////////////////////////////////////////

`default_nettype none

module noc_bridge_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import noc_bridge_pkg::*;

  localparam int NarrowDepth     = 4;
  localparam int WideDepth       = 4;
  localparam int ForceSendThresh = 3;
  localparam int RandCycles      = 1000;
  localparam int WindowCycles    = 60;
  localparam int DrainLimit      = 200;
  // seven windows and six drain waits over all phases, with margin
  localparam int TimeoutCycles   = 2 * (RandCycles + 6 * DrainLimit + 7 * WindowCycles);

  logic         clk_i = 1'b0;
  logic         rst_n_i;
  logic         narrow_valid_i, narrow_ready_o, wide_valid_i, wide_ready_o;
  narrow_data_t narrow_data_i, narrow_data_o;
  wide_data_t   wide_data_i, wide_data_o;
  logic         narrow_valid_o, narrow_ready_i, wide_valid_o, wide_ready_i;
  logic         link_valid_o, link_ready_i, link_valid_i, link_ready_o;
  link_word_t   link_word_o, link_word_i;

  narrow_data_t narrow_sent[$];
  wide_data_t   wide_sent[$];
  logic [31:0]  lfsr_q = 32'hf235;
  logic         narrow_on, wide_on, narrow_hold, wide_hold, out_rand;
  logic         narrow_acc, wide_acc, cred_only_seen;
  string        test_name;
  int           value_errs = 0;
  int           other_errs = 0;
  int           cycles = 0;
  int           i;

  noc_bridge #(
    .NarrowDepth(NarrowDepth), .WideDepth(WideDepth), .ForceSendThresh(ForceSendThresh)
  ) noc_bridge_inst (.*);

  bind noc_bridge noc_bridge_checker #(
    .NarrowDepth(NarrowDepth), .WideDepth(WideDepth)
  ) u_link_checker (
    .clk_i, .rst_n_i,
    .link_out_valid_i(link_valid_o), .link_out_ready_i(link_ready_i),
    .link_out_word_i(link_word_o),
    .link_in_valid_i(link_valid_i), .link_in_ready_i(link_ready_o),
    .link_in_word_i(link_word_i),
    .narrow_pop_i(narrow_valid_o && narrow_ready_i),
    .wide_pop_i(wide_valid_o && wide_ready_i),
    .narrow_fill_i(u_narrow_fifo.count_q), .wide_fill_i(u_wide_fifo.count_q),
    .narrow_out_valid_i(narrow_valid_o), .wide_out_valid_i(wide_valid_o)
  );

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////
  // random source
  ////////////////////////////////////////

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic take_bit();
    lfsr_q = lfsr_next(lfsr_q);
    return lfsr_q[0];
  endfunction

  function automatic logic [63:0] take_word(input int nbits);
    logic [63:0] w;
    w = '0;
    for (int b = 0; b < nbits; b++) begin
      w = {w[62:0], take_bit()};
    end
    return w;
  endfunction

  ////////////////////////////////////////
  // per-cycle drive and sample
  ////////////////////////////////////////

  task automatic check_narrow();
    narrow_data_t exp;
    if (narrow_sent.size() == 0) begin
      $display("%s: narrow output delivered a flit that was never sent", test_name);
      other_errs++;
    end else begin
      exp = narrow_sent.pop_front();
      assert (narrow_data_o == exp) else begin
        $display("[FAIL] %s: narrow flit expected %h, actual %h", test_name, exp, narrow_data_o);
        value_errs++;
      end
    end
  endtask

  task automatic check_wide();
    wide_data_t exp;
    if (wide_sent.size() == 0) begin
      $display("%s: wide output delivered a flit that was never sent", test_name);
      other_errs++;
    end else begin
      exp = wide_sent.pop_front();
      assert (wide_data_o == exp) else begin
        $display("[FAIL] %s: wide flit expected %h, actual %h", test_name, exp, wide_data_o);
        value_errs++;
      end
    end
  endtask

  task automatic step();
    @(negedge clk_i);
    // loopback, a word crosses only when the far side is ready
    link_ready_i = take_bit();
    link_valid_i = link_valid_o && link_ready_i;
    link_word_i  = link_word_o;
    // a pending flit holds until accepted
    if (!narrow_valid_i || narrow_acc) begin
      narrow_valid_i = narrow_on && take_bit();
      narrow_data_i  = narrow_data_t'(take_word(NarrowWidth));
    end
    if (!wide_valid_i || wide_acc) begin
      wide_valid_i = wide_on && take_bit();
      wide_data_i  = take_word(WideWidth);
    end
    narrow_ready_i = !narrow_hold && (!out_rand || take_bit());
    wide_ready_i   = !wide_hold && (!out_rand || take_bit());
    #1;
    narrow_acc = narrow_valid_i && narrow_ready_o;
    wide_acc   = wide_valid_i && wide_ready_o;
    if (narrow_acc) narrow_sent.push_back(narrow_data_i);
    if (wide_acc) wide_sent.push_back(wide_data_i);
    if (narrow_valid_o && narrow_ready_i) check_narrow();
    if (wide_valid_o && wide_ready_i) check_wide();
    if (link_valid_o && !link_word_o.data_valid) cred_only_seen = 1'b1;
  endtask

  function automatic logic outstanding();
    return narrow_sent.size() != 0 || wide_sent.size() != 0 || narrow_valid_i || wide_valid_i;
  endfunction

  // stop the inputs and wait for every accepted flit to come out
  task automatic drain();
    int n;
    narrow_on   = 1'b0;
    wide_on     = 1'b0;
    narrow_hold = 1'b0;
    wide_hold   = 1'b0;
    out_rand    = 1'b0;
    n = 0;
    while (outstanding() && n < DrainLimit) begin
      step();
      n++;
    end
    if (outstanding()) begin
      $display("%s: flits still outstanding after %0d cycles", test_name, DrainLimit);
      other_errs++;
    end
  endtask

  // one channel offers flits while its output is held
  task automatic credit_bound(input logic use_wide, input int depth);
    int accepted;
    accepted    = 0;
    narrow_on   = !use_wide;
    wide_on     = use_wide;
    narrow_hold = !use_wide;
    wide_hold   = use_wide;
    out_rand    = 1'b0;
    repeat (WindowCycles) begin
      step();
      if (use_wide ? wide_acc : narrow_acc) accepted++;
    end
    assert (accepted == depth) else begin
      $display("[FAIL] %s: accepted flits expected %0d, actual %0d", test_name, depth, accepted);
      value_errs++;
    end
  endtask

  task automatic bound_and_resume(input logic use_wide, input int depth);
    credit_bound(use_wide, depth);
    narrow_hold = 1'b0;
    wide_hold   = 1'b0;
    repeat (WindowCycles) step();
    drain();
  endtask

  task automatic print_counts();
    $display("errors: %0d value mismatches, %0d other, %0d assertion failures",
             value_errs, other_errs, noc_bridge_inst.u_link_checker.fail_count);
  endtask

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
      print_counts();
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    rst_n_i        = 1'b0;
    narrow_valid_i = 1'b0;
    narrow_data_i  = '0;
    wide_valid_i   = 1'b0;
    wide_data_i    = '0;
    narrow_ready_i = 1'b0;
    wide_ready_i   = 1'b0;
    link_ready_i   = 1'b0;
    link_valid_i   = 1'b0;
    link_word_i    = '0;
    narrow_acc     = 1'b0;
    wide_acc       = 1'b0;
    cred_only_seen = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;

    // ordering on both channels under random back-pressure
    test_name   = "random_traffic";
    narrow_on   = 1'b1;
    wide_on     = 1'b1;
    narrow_hold = 1'b0;
    wide_hold   = 1'b0;
    out_rand    = 1'b1;
    repeat (RandCycles) step();
    drain();

    test_name = "narrow_credit_bound";
    bound_and_resume(1'b0, NarrowDepth);
    test_name = "wide_credit_bound";
    bound_and_resume(1'b1, WideDepth);

    // fill the narrow queue, then pop it with the inputs stopped
    test_name = "credit_return";
    credit_bound(1'b0, NarrowDepth);
    narrow_on      = 1'b0;
    cred_only_seen = 1'b0;
    narrow_hold    = 1'b0;
    i = 0;
    while (!cred_only_seen && i < DrainLimit) begin
      step();
      i++;
    end
    if (!cred_only_seen) begin
      $display("%s: no credit-only link word after the narrow queue drained", test_name);
      other_errs++;
    end
    drain();
    test_name = "credit_refill";
    bound_and_resume(1'b0, NarrowDepth);

    print_counts();
    if (value_errs + other_errs + noc_bridge_inst.u_link_checker.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hdl/noc_bridge_pkg.sv
hdl/vc_credit_counter.sv
hdl/link_tx_arbiter.sv
hdl/link_rx_demux.sv
hdl/vc_rx_fifo.sv
hdl/noc_bridge.sv
dv/noc_bridge_checker.sv
dv/noc_bridge_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := noc_bridge_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
